// File: Makefile
TOP = tb_cpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: build
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

// File: hw/alu.sv
`timescale 1ns/10ps

module alu
  import core_pkg::*;
(
  input  logic [31 : 0] a,
  input  logic [31 : 0] b,
  input  alu_op_type    op,
  output logic [31 : 0] result,
  output logic          cond
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ADD:     result = a + b;
      SUB:     result = a - b;
      AND:     result = a & b;
      OR:      result = a | b;
      XOR:     result = a ^ b;
      SLT:     result = {31'b0, $signed(a) < $signed(b)};
      SLL:     result = a << shamt;
      SRL:     result = a >> shamt; // Logical shift.
      PASS_B:  result = b;
      default: result = a + b;
    endcase
  end

  // Equality for BEQ and BNE.
  assign cond = (a == b);

endmodule

// File: hw/control_fsm.sv
`timescale 1ns/10ps

module control_fsm
  import core_pkg::*;
#(
  parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
  input  logic           clk,
  input  logic           rst_n,
  output imem_req_type   imem_req,
  input  mem_resp_type   imem_resp,
  output dmem_req_type   dmem_req,
  input  mem_resp_type   dmem_resp,
  output logic [31 : 0]  instr,
  input  decode_out_type dec,
  input  logic [31 : 0]  rs1_data,
  input  logic [31 : 0]  rs2_data,
  output logic [31 : 0]  alu_a,
  output logic [31 : 0]  alu_b,
  output alu_op_type     alu_op,
  input  logic [31 : 0]  alu_result,
  input  logic           alu_cond,
  output logic           rf_we,
  output logic [4 : 0]   rf_rd,
  output logic [31 : 0]  rf_wdata
);

  fsm_state_type state;
  logic [31:0]   pc;
  logic [31:0]   pc_plus4;
  logic [31:0]   target;
  logic [31:0]   next_pc;
  logic          taken;
  logic [31:0]   instr_q;
  logic [31:0]   load_q;
  logic          imem_valid_q;
  logic          dmem_valid_q;
  logic          dmem_we_q;
  logic [31:0]   dmem_addr_q;
  logic [31:0]   dmem_wdata_q;
  logic          fetch_done;
  logic          data_done;

  assign fetch_done = (state == FETCH) && imem_valid_q && imem_resp.ready;
  assign data_done  = (state == MEMORY) && dmem_valid_q && dmem_resp.ready;

  assign pc_plus4 = pc + 32'd4;
  assign target   = pc + dec.imm; // Branch and JAL share the PC-relative form.
  assign taken    = dec.jump | (dec.branch & (alu_cond ^ dec.branch_ne));
  assign next_pc  = taken ? target : pc_plus4;

  assign alu_a  = rs1_data;
  assign alu_b  = dec.use_imm ? dec.imm : rs2_data;
  assign alu_op = dec.alu_op;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= FETCH;
      pc           <= RESET_VECTOR;
      imem_valid_q <= 1'b0;
      dmem_valid_q <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (!imem_valid_q) begin
            imem_valid_q <= 1'b1; // First request after reset.
          end else if (imem_resp.ready) begin
            imem_valid_q <= 1'b0;
            state        <= EXECUTE;
          end
        end
        EXECUTE: begin
          if (dec.illegal) begin
            state <= HALT;
          end else if (dec.mem_read || dec.mem_write) begin
            dmem_valid_q <= 1'b1;
            state        <= MEMORY;
          end else begin
            state <= WRITEBACK;
          end
        end
        MEMORY: begin
          if (dmem_resp.ready) begin
            dmem_valid_q <= 1'b0;
            state        <= WRITEBACK;
          end
        end
        WRITEBACK: begin
          pc           <= next_pc;
          imem_valid_q <= 1'b1; // Next fetch starts at once.
          state        <= FETCH;
        end
        default: state <= HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      instr_q <= imem_resp.rdata;
    end
    if (state == EXECUTE) begin
      dmem_we_q    <= dec.mem_write;
      dmem_addr_q  <= alu_result;
      dmem_wdata_q <= rs2_data;
    end
    if (data_done) begin
      load_q <= dmem_resp.rdata;
    end
  end

  assign instr = instr_q;

  assign imem_req.valid = imem_valid_q;
  assign imem_req.addr  = pc;

  assign dmem_req.valid = dmem_valid_q;
  assign dmem_req.we    = dmem_we_q;
  assign dmem_req.addr  = dmem_addr_q;
  assign dmem_req.wdata = dmem_wdata_q;

  // Register write only in WRITEBACK.
  assign rf_we    = (state == WRITEBACK) && dec.reg_write;
  assign rf_rd    = dec.rd;
  assign rf_wdata = dec.jump ? pc_plus4 : (dec.mem_read ? load_q : alu_result);

endmodule

// File: hw/core_pkg.sv
package core_pkg;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } imem_req_type;

  typedef struct packed {
    logic        valid;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dmem_req_type;

  // Shared by the instruction and data buses.
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } mem_resp_type;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL,
    PASS_B
  } alu_op_type;

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    alu_op_type  alu_op;
    logic        use_imm;   // ALU operand b from imm.
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        branch;
    logic        branch_ne;
    logic        jump;
    logic        illegal;
  } decode_out_type;

  typedef enum logic [2:0] {
    FETCH,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    HALT
  } fsm_state_type;

endpackage

// File: hw/cpu.sv
`timescale 1ns/10ps

module cpu
  import core_pkg::*;
#(
  parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  output logic          imemory_valid,
  output logic [31 : 0] imemory_addr,
  input  logic [31 : 0] imemory_rdata,
  input  logic          imemory_ready,
  output logic          dmemory_valid,
  output logic          dmemory_we,
  output logic [31 : 0] dmemory_addr,
  output logic [31 : 0] dmemory_wdata,
  input  logic [31 : 0] dmemory_rdata,
  input  logic          dmemory_ready
);

  imem_req_type   imem_req;
  mem_resp_type   imem_resp;
  dmem_req_type   dmem_req;
  mem_resp_type   dmem_resp;
  decode_out_type dec;
  logic [31:0]    instr;
  logic [31:0]    rs1_data;
  logic [31:0]    rs2_data;
  logic [31:0]    alu_a;
  logic [31:0]    alu_b;
  alu_op_type     alu_op;
  logic [31:0]    alu_result;
  logic           alu_cond;
  logic           rf_we;
  logic [4:0]     rf_rd;
  logic [31:0]    rf_wdata;

  control_fsm #(
    .RESET_VECTOR (RESET_VECTOR)
  ) control_fsm_comp (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_req   (imem_req),
    .imem_resp  (imem_resp),
    .dmem_req   (dmem_req),
    .dmem_resp  (dmem_resp),
    .instr      (instr),
    .dec        (dec),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_op     (alu_op),
    .alu_result (alu_result),
    .alu_cond   (alu_cond),
    .rf_we      (rf_we),
    .rf_rd      (rf_rd),
    .rf_wdata   (rf_wdata)
  );

  decoder decoder_comp (
    .instr (instr),
    .dec   (dec)
  );

  alu alu_comp (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result),
    .cond   (alu_cond)
  );

  register_file register_file_comp (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .wdata    (rf_wdata)
  );

  assign imemory_valid   = imem_req.valid;
  assign imemory_addr    = imem_req.addr;
  assign imem_resp.rdata = imemory_rdata;
  assign imem_resp.ready = imemory_ready;

  assign dmemory_valid   = dmem_req.valid;
  assign dmemory_we      = dmem_req.we;
  assign dmemory_addr    = dmem_req.addr;
  assign dmemory_wdata   = dmem_req.wdata;
  assign dmem_resp.rdata = dmemory_rdata;
  assign dmem_resp.ready = dmemory_ready;

endmodule

// File: hw/decoder.sv
`timescale 1ns/10ps

module decoder
  import rv_isa_pkg::*, core_pkg::*;
(
  input  logic [31 : 0]  instr,
  output decode_out_type dec
);

  instr_union  iw;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign iw = instr;

  assign imm_i = {{20{iw.i.imm[11]}}, iw.i.imm};
  assign imm_s = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
  assign imm_b = {{20{iw.b.imm12}}, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
  assign imm_u = {iw.u.imm, 12'h000};
  assign imm_j = {{12{iw.j.imm20}}, iw.j.imm19_12, iw.j.imm11, iw.j.imm10_1, 1'b0};

  always_comb begin
    dec        = '0;
    dec.rs1    = iw.r.rs1;
    dec.rs2    = iw.r.rs2;
    dec.rd     = iw.r.rd;
    dec.alu_op = ADD;
    case (iw.r.opcode)
      OP_LUI: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.alu_op    = PASS_B;
        dec.reg_write = 1'b1;
      end
      OP_IMM: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        case (iw.i.funct3)
          F3_ADD:  dec.alu_op = ADD;
          F3_AND:  dec.alu_op = AND;
          F3_OR:   dec.alu_op = OR;
          F3_XOR:  dec.alu_op = XOR;
          F3_SLT:  dec.alu_op = SLT;
          default: dec.illegal = 1'b1;
        endcase
      end
      OP_REG: begin
        dec.reg_write = 1'b1;
        case ({iw.r.funct7, iw.r.funct3})
          {F7_BASE, F3_ADD}: dec.alu_op = ADD;
          {F7_SUB, F3_ADD}:  dec.alu_op = SUB;
          {F7_BASE, F3_AND}: dec.alu_op = AND;
          {F7_BASE, F3_OR}:  dec.alu_op = OR;
          {F7_BASE, F3_XOR}: dec.alu_op = XOR;
          {F7_BASE, F3_SLT}: dec.alu_op = SLT;
          {F7_BASE, F3_SLL}: dec.alu_op = SLL;
          {F7_BASE, F3_SRL}: dec.alu_op = SRL;
          default:           dec.illegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.mem_read  = 1'b1;
        dec.illegal   = (iw.i.funct3 != F3_LW); // Word loads only.
      end
      OP_STORE: begin
        dec.imm       = imm_s;
        dec.use_imm   = 1'b1;
        dec.mem_write = 1'b1;
        dec.illegal   = (iw.s.funct3 != F3_SW);
      end
      OP_BRANCH: begin
        dec.imm    = imm_b;
        dec.branch = 1'b1;
        case (iw.b.funct3)
          F3_BEQ:  dec.branch_ne = 1'b0;
          F3_BNE:  dec.branch_ne = 1'b1;
          default: dec.illegal = 1'b1;
        endcase
      end
      OP_JAL: begin
        dec.imm       = imm_j;
        dec.jump      = 1'b1;
        dec.reg_write = 1'b1;
      end
      default: dec.illegal = 1'b1;
    endcase
  end

endmodule

// File: hw/register_file.sv
`timescale 1ns/10ps

module register_file
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic [4 : 0]  rs1,
  input  logic [4 : 0]  rs2,
  output logic [31 : 0] rs1_data,
  output logic [31 : 0] rs2_data,
  input  logic          we,
  input  logic [4 : 0]  rd,
  input  logic [31 : 0] wdata
);

  logic [31:0] regs [1:31]; // No storage for x0.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD = 3'b000; // Also SUB.
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_SW  = 3'b010;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt;

  // One view of the 32-bit word per encoding format.
  typedef union packed {
    r_fmt r;
    i_fmt i;
    s_fmt s;
    b_fmt b;
    u_fmt u;
    j_fmt j;
  } instr_union;

endpackage

// File: sources.f
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/decoder.sv
hw/alu.sv
hw/register_file.sv
hw/control_fsm.sv
hw/cpu.sv
test/cpu_properties.sv
test/tb_cpu.sv

// File: test/cpu_properties.sv
`timescale 1ns/10ps

module cpu_properties (
  input logic          clk,
  input logic          rst_n,
  input logic          imemory_valid,
  input logic [31 : 0] imemory_addr,
  input logic          imemory_ready,
  input logic          dmemory_valid,
  input logic          dmemory_we,
  input logic [31 : 0] dmemory_addr,
  input logic [31 : 0] dmemory_wdata,
  input logic          dmemory_ready
);

  // Both valids come from registers that reset clears.
  idle_in_reset: assert property (@(posedge clk) !rst_n |=> !imemory_valid && !dmemory_valid)
    else $error("bus valid high during reset");

  fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
    imemory_valid && !imemory_ready |=> imemory_valid && $stable(imemory_addr))
    else $error("fetch request changed before ready");

  data_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dmemory_valid && !dmemory_ready |=>
      dmemory_valid && $stable({dmemory_we, dmemory_addr, dmemory_wdata}))
    else $error("data request changed before ready");

  one_bus: assert property (@(posedge clk) disable iff (!rst_n)
    !(imemory_valid && dmemory_valid))
    else $error("both buses requested at once");

  fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imemory_valid |-> imemory_addr[1:0] == 2'b00)
    else $error("fetch address not word aligned");

endmodule

bind cpu cpu_properties cpu_properties_comp (.*);

// File: test/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu
  import rv_isa_pkg::*;
();

  localparam logic [31:0] RESET_VECTOR   = 32'h0000_0100;
  localparam logic [31:0] DATA_BASE      = 32'h0000_2000;
  localparam int          DATA_WORDS     = 64;
  localparam int          BODY_LENGTH    = 158;
  localparam int          TIMEOUT_CYCLES = 40;
  localparam int          MAX_FETCHES    = 400;

  logic        clk;
  logic        rst_n;
  logic        imemory_valid;
  logic [31:0] imemory_addr;
  logic [31:0] imemory_rdata;
  logic        imemory_ready;
  logic        dmemory_valid;
  logic        dmemory_we;
  logic [31:0] dmemory_addr;
  logic [31:0] dmemory_wdata;
  logic [31:0] dmemory_rdata;
  logic        dmemory_ready;

  logic [31:0] imem [0:511];
  logic [31:0] dmem [0:DATA_WORDS-1];
  logic [31:0] model_regs [0:31];
  logic [31:0] model_pc;
  logic [31:0] halt_pc;
  logic [31:0] word;
  logic [8:0]  emit_index;
  integer      seed;
  int          fetches;
  int          halt_fetches;
  int          stores;

  cpu #(
    .RESET_VECTOR (RESET_VECTOR)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_we    (dmemory_we),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

  always #2 clk = ~clk;

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch %s: expected 0x%08h, actual 0x%08h",
                                  name, expected, actual));
    end
  endtask

  task automatic emit(input logic [31:0] instr);
    imem[emit_index] = instr;
    emit_index++;
  endtask

  task automatic build_program;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    int unsigned kind;
    emit_index = RESET_VECTOR[10:2];
    emit({DATA_BASE[31:12], 5'd31, OP_LUI}); // x31 is the data base.
    for (int r = 1; r <= 4; r++) begin
      emit({20'(rand_below(32'h100000)), 5'(r), OP_LUI});
      emit(enc_i(OP_IMM, F3_ADD, 5'(r), 5'(r), 12'(rand_below(4096))));
    end
    emit(enc_i(OP_IMM, F3_ADD, 5'd0, 5'd1, 12'd77)); // Write to x0, then store it.
    emit(enc_s(5'd0, 5'd31, 12'd0));
    for (int n = 0; n < BODY_LENGTH; n++) begin
      rd   = 5'(rand_below(31));
      rs1  = 5'(rand_below(31));
      rs2  = 5'(rand_below(31));
      kind = rand_below(10);
      case (kind)
        0, 1, 2: begin
          f3 = 3'(rand_below(7));
          if (f3 == 3'b011) begin
            f3 = F3_AND; // SLTU is outside the subset.
          end
          emit(enc_r((f3 == F3_ADD && rand_below(2) == 0) ? F7_SUB : F7_BASE,
                     f3, rd, rs1, rs2));
        end
        3, 4: begin
          case (rand_below(5))
            0: f3 = F3_ADD;
            1: f3 = F3_AND;
            2: f3 = F3_OR;
            3: f3 = F3_XOR;
            default: f3 = F3_SLT;
          endcase
          emit(enc_i(OP_IMM, f3, rd, rs1, 12'(rand_below(4096))));
        end
        5: emit({20'(rand_below(32'h100000)), rd, OP_LUI});
        6: emit(enc_i(OP_LOAD, F3_LW, rd, 5'd31, 12'(rand_below(DATA_WORDS) * 4)));
        7: emit(enc_s(rs2, 5'd31, 12'(rand_below(DATA_WORDS) * 4)));
        8: emit(enc_b((rand_below(2) == 0) ? F3_BEQ : F3_BNE, 5'(rand_below(4)),
                      5'(rand_below(4)), 13'((rand_below(7) + 2) * 4)));
        default: emit(enc_j(rd, 21'((rand_below(7) + 2) * 4))); // Forward only.
      endcase
    end
    for (int r = 0; r < 31; r++) begin
      emit(enc_s(5'(r), 5'd31, 12'(r * 4)));
    end
    halt_pc = {21'd0, emit_index, 2'b00};
    emit(enc_j(5'd0, 21'd0));
  endtask

  task automatic wait_fetch_request;
    int cycles;
    cycles = 0;
    while (!imemory_valid) begin
      if (dmemory_valid) begin
        stop_with_failure("core started a data access where none was due");
      end
      if (cycles == TIMEOUT_CYCLES) begin
        stop_with_failure("core stopped requesting instructions");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_data_request;
    int cycles;
    cycles = 0;
    while (!dmemory_valid) begin
      if (imemory_valid) begin
        stop_with_failure("core fetched before its data access");
      end
      if (cycles == TIMEOUT_CYCLES) begin
        stop_with_failure("core stopped requesting data");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic answer_fetch(input logic [31:0] instr);
    repeat (rand_below(4)) @(negedge clk);
    imemory_rdata = instr;
    imemory_ready = 1'b1;
    @(negedge clk);
    imemory_ready = 1'b0;
  endtask

  task automatic answer_data(input logic [31:0] rdata);
    repeat (rand_below(4)) @(negedge clk);
    dmemory_rdata = rdata;
    dmemory_ready = 1'b1;
    @(negedge clk);
    dmemory_ready = 1'b0;
  endtask

  task automatic load_word(input logic [31:0] addr, output logic [31:0] value);
    logic [31:0] offset;
    wait_data_request();
    check_value("load_addr", addr, dmemory_addr);
    check_value("load_we", 32'd0, 32'(dmemory_we));
    offset = addr - DATA_BASE;
    value  = dmem[offset[7:2]];
    answer_data(value);
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] offset;
    wait_data_request();
    check_value("store_addr", addr, dmemory_addr);
    check_value("store_we", 32'd1, 32'(dmemory_we));
    check_value("store_data", data, dmemory_wdata);
    offset = addr - DATA_BASE;
    dmem[offset[7:2]] = data;
    answer_data(32'd0);
    stores++;
  endtask

  // Instruction-set model that runs one instruction per call.
  task automatic run_instruction(input logic [31:0] w);
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] result;
    logic [31:0] next_pc;
    logic        write_rd;
    f3       = w[14:12];
    rd       = w[11:7];
    a        = model_regs[w[19:15]];
    b        = model_regs[w[24:20]];
    imm_i    = {{20{w[31]}}, w[31:20]};
    imm_s    = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    result   = 32'd0;
    write_rd = 1'b1;
    next_pc  = model_pc + 32'd4;
    case (w[6:0])
      OP_LUI: result = {w[31:12], 12'h000};
      OP_IMM: begin
        case (f3)
          F3_ADD:  result = a + imm_i;
          F3_AND:  result = a & imm_i;
          F3_OR:   result = a | imm_i;
          F3_XOR:  result = a ^ imm_i;
          F3_SLT:  result = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
          default: stop_with_failure("model met an unknown immediate operation");
        endcase
      end
      OP_REG: begin
        case (f3)
          F3_ADD:  result = w[30] ? a - b : a + b;
          F3_SLL:  result = a << b[4:0];
          F3_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          F3_XOR:  result = a ^ b;
          F3_SRL:  result = a >> b[4:0];
          F3_OR:   result = a | b;
          F3_AND:  result = a & b;
          default: stop_with_failure("model met an unknown register operation");
        endcase
      end
      OP_LOAD: load_word(a + imm_i, result);
      OP_STORE: begin
        write_rd = 1'b0;
        store_word(a + imm_s, b);
      end
      OP_BRANCH: begin
        write_rd = 1'b0;
        if ((a == b) != (f3 == F3_BNE)) begin
          next_pc = model_pc + imm_b;
        end
      end
      OP_JAL: begin
        result  = model_pc + 32'd4; // Link address.
        next_pc = model_pc + imm_j;
      end
      default: stop_with_failure("model met an opcode outside the subset");
    endcase
    if (write_rd && rd != 5'd0) begin
      model_regs[rd] = result;
    end
    model_pc = next_pc;
  endtask

  initial begin
    seed          = 32'h4033;
    clk           = 1'b0;
    rst_n         = 1'b0;
    imemory_rdata = 32'd0;
    imemory_ready = 1'b0;
    dmemory_rdata = 32'd0;
    dmemory_ready = 1'b0;
    stores        = 0;
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = 32'd0;
    end
    for (int k = 0; k < DATA_WORDS; k++) begin
      dmem[k] = $random(seed);
    end
    build_program();
    model_pc = RESET_VECTOR;
    repeat (3) begin
      @(negedge clk);
      check_value("reset_imem_valid", 32'd0, 32'(imemory_valid));
      check_value("reset_dmem_valid", 32'd0, 32'(dmemory_valid));
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_value("first_fetch_valid", 32'd1, 32'(imemory_valid));
    fetches      = 0;
    halt_fetches = 0;
    while (halt_fetches < 2 && fetches < MAX_FETCHES) begin
      wait_fetch_request();
      check_value($sformatf("fetch_addr %0d", fetches), model_pc, imemory_addr);
      fetches++;
      if (model_pc == halt_pc) begin
        halt_fetches++;
      end
      if (halt_fetches < 2) begin
        word = imem[model_pc[10:2]];
        answer_fetch(word);
        run_instruction(word);
      end
    end
    if (halt_fetches == 2) begin
      $display("%0d fetches and %0d stores checked", fetches, stores);
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_failure("program did not reach its halt");
    end
  end

endmodule
